/* compile.f */
+incdir+include
logic/streamer_pkg.sv
logic/streamer_ctrl.sv
logic/stream_source.sv
logic/stream_sink.sv
logic/tcdm_mux.sv
logic/redmule_streamer.sv
verif/tb_clk_gen.sv
verif/tb_streamer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the streamer testbench with Verilator, from the project root
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_streamer
LOG_FILE=sim.log

verilator --binary --timing --assert \
  --top-module tb_streamer \
  -f compile.f \
  -Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "Verilator build failed with status ${status}"
  exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
status=$?
cat "${LOG_FILE}"
if [ ${status} -ne 0 ]; then
  echo "Simulation exited with status ${status}"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "${LOG_FILE}"; then
  exit 0
fi
echo "Pass message not found in ${LOG_FILE}"
exit 1

/* verif/streamer_vectors.txt */
# x_base w_base y_base z_base len stride seed_mask z_start, all hex
# Z writes never touch the X, W and Y read regions
0000 0100 0200 0800 10 01 00000000 00000100
1000 2000 3000 4000 08 03 a5a5a5a5 12340000
0050 0060 0070 0f00 01 01 0000ffff deadbeef
0400 0600 0a00 c000 20 02 5a5a0000 00000000
7000 7100 7200 7300 04 10 ffffffff 80000000
e000 e000 e000 f000 0c 01 13579bdf 00ff00ff
0123 4567 89ab cdef 01 07 00c0ffee 11111111
2000 2800 3000 a000 40 04 0f0f0f0f 7fffffff
0010 0020 0030 0040 03 ff 76543210 fffffffe

/* verif/tb_streamer.sv */
/*
 * Streamer testbench. Run from the project root, jobs come from verif/streamer_vectors.txt.
 * Memory model covers the full word address space. Grants, stream readies and Z valids
 * are random at about 75 percent. Z regions must not overlap the X, W and Y regions.
 */
`include "streamer_cfg.svh"

module tb_streamer
  import streamer_pkg::*;
();

  localparam int NSRC            = `STREAMER_NUM_SRC;
  localparam int MEM_WORDS       = 1 << `STREAMER_ADDR_W;
  localparam int MAX_TESTS       = 32;
  localparam int CYCLES_PER_WORD = 64;
  localparam int TIMEOUT_MARGIN  = 1000;

  logic            clk;
  logic            arst_n;
  // DUT inputs, all start at a known value
  logic            start      = 1'b0;
  addr_t           x_base     = '0;
  addr_t           w_base     = '0;
  addr_t           y_base     = '0;
  addr_t           z_base     = '0;
  len_t            len        = '0;
  len_t            stride     = '0;
  logic [NSRC-1:0] s_ready    = '0;
  logic            z_valid    = 1'b0;
  data_t           z_data     = '0;
  logic            mem_gnt    = 1'b0;
  logic            mem_rvalid = 1'b0;
  data_t           mem_rdata  = '0;
  // DUT outputs
  logic [NSRC-1:0] s_valid;
  data_t           s_data [NSRC];
  logic            z_ready;
  logic            mem_req;
  addr_t           mem_addr;
  logic            mem_wen;
  data_t           mem_wdata;
  logic            busy;
  logic            done;

  // One cycle marker of a new job, seen by the models with the DUT start
  logic            new_job = 1'b0;
  int              seed    = 32'h3b49a7b7;
  int              err_count;
  int              cycle_cnt;
  int              cycle_limit;
  // Job list from the vector file
  logic [31:0]     vec [MAX_TESTS][8];
  int              num_tests;
  int              total_words;
  // Current job
  logic [31:0]     cur_base [NSRC];
  logic [31:0]     cur_zbase;
  int              cur_len;
  int              cur_stride;
  logic [31:0]     cur_mask;
  logic [31:0]     cur_zstart;
  // Memory model and the image expected after a job
  data_t           mem [MEM_WORDS];
  data_t           exp_mem [MEM_WORDS];
  logic            req_held;
  addr_t           held_addr;
  logic            held_wen;
  data_t           held_wdata;
  // Z driver progress
  int              z_sent;
  int              z_len;
  // Stream monitors
  string           chan_name [NSRC] = '{"X", "W", "Y"};
  logic [NSRC-1:0] held;
  data_t           held_data [NSRC];
  int              rx_count [NSRC];
  int              done_count;

  tb_clk_gen i_tb_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  redmule_streamer i_redmule_streamer (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .start_i      ( start      ),
    .x_base_i     ( x_base     ),
    .w_base_i     ( w_base     ),
    .y_base_i     ( y_base     ),
    .z_base_i     ( z_base     ),
    .len_i        ( len        ),
    .stride_i     ( stride     ),
    .x_valid_o    ( s_valid[0] ),
    .x_data_o     ( s_data[0]  ),
    .x_ready_i    ( s_ready[0] ),
    .w_valid_o    ( s_valid[1] ),
    .w_data_o     ( s_data[1]  ),
    .w_ready_i    ( s_ready[1] ),
    .y_valid_o    ( s_valid[2] ),
    .y_data_o     ( s_data[2]  ),
    .y_ready_i    ( s_ready[2] ),
    .z_valid_i    ( z_valid    ),
    .z_data_i     ( z_data     ),
    .z_ready_o    ( z_ready    ),
    .mem_req_o    ( mem_req    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wen_o    ( mem_wen    ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .busy_o       ( busy       ),
    .done_o       ( done       )
  );

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      err_count++;
      $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Word k of a load stream, memory holds address XOR mask
  function automatic data_t load_word(input logic [31:0] base, input int k, input int step,
                                      input data_t mask);
    addr_t a;
    a = addr_t'(base + 32'(k * step));
    return data_t'(a) ^ mask;
  endfunction

  // Memory, grants, stream readies and the Z stream
  always @(posedge clk) begin : env_model
    // A stalled request must hold until granted
    if (req_held) begin
      compare_value(32'(mem_req), 32'd1, "memory request dropped before grant");
      compare_value(32'(mem_addr), 32'(held_addr), "memory address changed before grant");
      compare_value(32'(mem_wen), 32'(held_wen), "memory wen changed before grant");
      compare_value(mem_wdata, held_wdata, "memory wdata changed before grant");
    end
    req_held   = mem_req && !mem_gnt;
    held_addr  = mem_addr;
    held_wen   = mem_wen;
    held_wdata = mem_wdata;
    if (new_job) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        mem[addr_t'(a)] = data_t'(a) ^ cur_mask;
      end
    end
    // Read data one cycle after the grant, writes land at the grant
    if (mem_req && mem_gnt) begin
      if (mem_wen) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= mem[mem_addr];
      end else begin
        mem_rvalid     <= 1'b0;
        mem[mem_addr]   = mem_wdata;
      end
    end else begin
      mem_rvalid <= 1'b0;
    end
    mem_gnt <= ($random(seed) & 3) != 0;
    for (int i = 0; i < NSRC; i++) begin
      s_ready[i] <= ($random(seed) & 3) != 0;
    end
    // Z engine: word k is start plus k, valid held until taken
    if (new_job) begin
      z_sent = 0;
      z_len  = cur_len;
      z_valid <= 1'b0;
    end else begin
      if (z_valid && z_ready) begin
        z_sent = z_sent + 1;
      end
      if (!(z_valid && !z_ready)) begin
        if (z_sent < z_len && ($random(seed) & 3) != 0) begin
          z_valid <= 1'b1;
          z_data  <= cur_zstart + 32'(z_sent);
        end else begin
          z_valid <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin : stream_monitor
    if (new_job) begin
      for (int i = 0; i < NSRC; i++) begin
        rx_count[i] = 0;
      end
      done_count = 0;
    end else if (done) begin
      done_count = done_count + 1;
      compare_value(32'(busy), 32'd0, "busy high in the done cycle");
    end
    for (int i = 0; i < NSRC; i++) begin
      // Stalled word must stay put
      if (held[i]) begin
        compare_value(32'(s_valid[i]), 32'd1,
                      $sformatf("%s valid dropped while stalled", chan_name[i]));
        compare_value(s_data[i], held_data[i],
                      $sformatf("%s data changed while stalled", chan_name[i]));
      end
      if (s_valid[i] && s_ready[i]) begin
        if (rx_count[i] < cur_len) begin
          compare_value(s_data[i], load_word(cur_base[i], rx_count[i], cur_stride, cur_mask),
                        $sformatf("%s word %0d", chan_name[i], rx_count[i]));
        end
        rx_count[i] = rx_count[i] + 1;
      end
      held[i]      = s_valid[i] && !s_ready[i];
      held_data[i] = s_data[i];
    end
  end

  always @(posedge clk) begin : timeout_guard
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, a job never reached done", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic read_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] xb, wb, yb, zb, ln, st, mk, zs;
    fd = $fopen("verif/streamer_vectors.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open verif/streamer_vectors.txt");
      err_count++;
    end else begin
      while (!$feof(fd) && num_tests < MAX_TESTS) begin
        n = $fgets(line, fd);
        // Comment and blank lines give fewer than 8 fields
        if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h",
                             xb, wb, yb, zb, ln, st, mk, zs) == 8) begin
          vec[num_tests] = '{xb, wb, yb, zb, ln, st, mk, zs};
          total_words    = total_words + 4 * int'(ln);
          num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_memory();
    addr_t za;
    for (int a = 0; a < MEM_WORDS; a++) begin
      exp_mem[addr_t'(a)] = data_t'(a) ^ cur_mask;
    end
    for (int k = 0; k < cur_len; k++) begin
      za          = addr_t'(cur_zbase + 32'(k * cur_stride));
      exp_mem[za] = cur_zstart + 32'(k);
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      compare_value(mem[addr_t'(a)], exp_mem[addr_t'(a)],
                    $sformatf("memory word at %h", addr_t'(a)));
    end
  endtask

  task automatic run_job(input int t);
    @(posedge clk);
    for (int i = 0; i < NSRC; i++) begin
      cur_base[i] = vec[t][i];
    end
    cur_zbase  = vec[t][3];
    cur_len    = int'(vec[t][4]);
    cur_stride = int'(vec[t][5]);
    cur_mask   = vec[t][6];
    cur_zstart = vec[t][7];
    x_base  <= addr_t'(vec[t][0]);
    w_base  <= addr_t'(vec[t][1]);
    y_base  <= addr_t'(vec[t][2]);
    z_base  <= addr_t'(vec[t][3]);
    len     <= len_t'(vec[t][4]);
    stride  <= len_t'(vec[t][5]);
    start   <= 1'b1;
    new_job <= 1'b1;
    @(posedge clk);
    start   <= 1'b0;
    new_job <= 1'b0;
    @(posedge clk);
    compare_value(32'(busy), 32'd1, "busy one cycle after start");
    // Extra start while busy, the job must run on untouched
    start <= 1'b1;
    @(posedge clk);
    compare_value(32'(busy), 32'd1, "busy while the extra start is seen");
    start <= 1'b0;
    while (done !== 1'b1) @(posedge clk);
    // A few idle cycles catch a second done or extra words
    repeat (4) @(posedge clk);
    compare_value(done_count, 32'd1, $sformatf("done pulses in job %0d", t));
    for (int i = 0; i < NSRC; i++) begin
      compare_value(rx_count[i], cur_len, $sformatf("%s word count in job %0d", chan_name[i], t));
    end
    compare_value(z_sent, cur_len, $sformatf("Z words taken in job %0d", t));
    check_memory();
  endtask

  initial begin : main
    int t;
    read_vectors();
    if (num_tests == 0) begin
      $display("Error: no test vectors were read");
      err_count++;
    end
    cycle_limit = CYCLES_PER_WORD * total_words + TIMEOUT_MARGIN;
    while (arst_n !== 1'b1) @(posedge clk);
    @(posedge clk);
    // Quiet outputs out of reset
    compare_value(32'(busy), 32'd0, "busy after reset");
    compare_value(32'(done), 32'd0, "done after reset");
    compare_value(32'(s_valid), 32'd0, "stream valids after reset");
    compare_value(32'(z_ready), 32'd0, "z_ready after reset");
    compare_value(32'(mem_req), 32'd0, "mem_req after reset");
    for (t = 0; t < num_tests; t++) begin
      run_job(t);
    end
    repeat (2) @(posedge clk);
    $display("Run complete: %0d tests, %0d errors", num_tests, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
/*
 * Testbench clock and reset. Period of 100 time units.
 * Reset is low for the first 4 rising edges and released on an edge.
 */
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

/* logic/redmule_streamer.sv */
/*
 * Streamer top. X, W, Y load and Z store share one word-wide memory port.
 * All channels use the same len and stride for a job.
 */
`include "streamer_cfg.svh"

module redmule_streamer
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  start_i,
  input  addr_t x_base_i,
  input  addr_t w_base_i,
  input  addr_t y_base_i,
  input  addr_t z_base_i,
  input  len_t  len_i,
  input  len_t  stride_i,
  output logic  x_valid_o,
  output data_t x_data_o,
  input  logic  x_ready_i,
  output logic  w_valid_o,
  output data_t w_data_o,
  input  logic  w_ready_i,
  output logic  y_valid_o,
  output data_t y_data_o,
  input  logic  y_ready_i,
  input  logic  z_valid_i,
  input  data_t z_data_i,
  output logic  z_ready_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_wen_o,
  output data_t mem_wdata_o,
  input  logic  mem_gnt_i,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  output logic  busy_o,
  output logic  done_o
);

  localparam int unsigned NSRC = `STREAMER_NUM_SRC;

  logic                chan_start;
  addr_t [NSRC-1:0]    src_base;
  logic  [NSRC-1:0]    src_valid;
  data_t [NSRC-1:0]    src_data;
  logic  [NSRC-1:0]    src_ready;
  logic  [NSRC-1:0]    src_done;
  logic                sink_done;
  // Mux ports, sink is the last one
  logic  [NSRC:0]      port_req;
  addr_t [NSRC:0]      port_addr;
  logic  [NSRC:0]      port_wen;
  data_t [NSRC:0]      port_wdata;
  logic  [NSRC:0]      port_gnt;
  logic  [NSRC:0]      port_rvalid;
  data_t               port_rdata;

  // Source order X, W, Y
  assign src_base  = {y_base_i, w_base_i, x_base_i};
  assign src_ready = {y_ready_i, w_ready_i, x_ready_i};
  assign x_valid_o = src_valid[0];
  assign x_data_o  = src_data[0];
  assign w_valid_o = src_valid[1];
  assign w_data_o  = src_data[1];
  assign y_valid_o = src_valid[2];
  assign y_data_o  = src_data[2];
  // Sources only read, the sink only writes
  assign port_wen  = {1'b0, {NSRC{1'b1}}};

  streamer_ctrl i_streamer_ctrl (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .start_i      ( start_i    ),
    .src_done_i   ( src_done   ),
    .sink_done_i  ( sink_done  ),
    .chan_start_o ( chan_start ),
    .busy_o       ( busy_o     ),
    .done_o       ( done_o     )
  );

  for (genvar i = 0; i < NSRC; i++) begin : gen_source
    assign port_wdata[i] = '0;

    stream_source i_stream_source (
      .clk_i          ( clk_i          ),
      .arst_n_i       ( arst_n_i       ),
      .start_i        ( chan_start     ),
      .base_i         ( src_base[i]    ),
      .len_i          ( len_i          ),
      .stride_i       ( stride_i       ),
      .req_o          ( port_req[i]    ),
      .addr_o         ( port_addr[i]   ),
      .req_gnt_i      ( port_gnt[i]    ),
      .rvalid_i       ( port_rvalid[i] ),
      .rdata_i        ( port_rdata     ),
      .stream_valid_o ( src_valid[i]   ),
      .stream_data_o  ( src_data[i]    ),
      .stream_ready_i ( src_ready[i]   ),
      .done_o         ( src_done[i]    )
    );
  end

  stream_sink i_stream_sink (
    .clk_i     ( clk_i            ),
    .arst_n_i  ( arst_n_i         ),
    .start_i   ( chan_start       ),
    .base_i    ( z_base_i         ),
    .len_i     ( len_i            ),
    .stride_i  ( stride_i         ),
    .z_valid_i ( z_valid_i        ),
    .z_data_i  ( z_data_i         ),
    .z_ready_o ( z_ready_o        ),
    .req_o     ( port_req[NSRC]   ),
    .addr_o    ( port_addr[NSRC]  ),
    .wdata_o   ( port_wdata[NSRC] ),
    .req_gnt_i ( port_gnt[NSRC]   ),
    .done_o    ( sink_done        )
  );

  tcdm_mux i_tcdm_mux (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .req_i        ( port_req     ),
    .addr_i       ( port_addr    ),
    .wen_i        ( port_wen     ),
    .wdata_i      ( port_wdata   ),
    .gnt_o        ( port_gnt     ),
    .rvalid_o     ( port_rvalid  ),
    .rdata_o      ( port_rdata   ),
    .mem_req_o    ( mem_req_o    ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wen_o    ( mem_wen_o    ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  )
  );

endmodule

/* logic/tcdm_mux.sv */
/*
 * Round-robin share of one memory port among four requesters.
 * Read data comes back exactly one cycle after the grant; writes get no response.
 */
`include "streamer_cfg.svh"

module tcdm_mux
  import streamer_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic  [`STREAMER_NUM_SRC:0] req_i,
  input  addr_t [`STREAMER_NUM_SRC:0] addr_i,
  input  logic  [`STREAMER_NUM_SRC:0] wen_i,
  input  data_t [`STREAMER_NUM_SRC:0] wdata_i,
  output logic  [`STREAMER_NUM_SRC:0] gnt_o,
  output logic  [`STREAMER_NUM_SRC:0] rvalid_o,
  output data_t                       rdata_o,
  output logic                        mem_req_o,
  output addr_t                       mem_addr_o,
  output logic                        mem_wen_o,
  output data_t                       mem_wdata_o,
  input  logic                        mem_gnt_i,
  input  logic                        mem_rvalid_i,
  input  data_t                       mem_rdata_i
);

  localparam int unsigned NUM_PORTS = `STREAMER_NUM_SRC + 1;

  port_id_t ptr_q;
  port_id_t rr_sel;
  port_id_t sel;
  logic     any_req;
  // Stalled request keeps its slot until granted
  logic     lock_q;
  port_id_t lock_id_q;
  // Owner of the read granted last cycle
  port_id_t rd_id_q;
  logic     mem_fire;

  // First requester at or after the pointer
  always_comb begin : p_arb
    port_id_t cand;
    any_req = 1'b0;
    rr_sel  = ptr_q;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      cand = ptr_q + port_id_t'(i);
      if (!any_req && req_i[cand]) begin
        any_req = 1'b1;
        rr_sel  = cand;
      end
    end
  end

  assign sel         = lock_q ? lock_id_q : rr_sel;
  assign mem_req_o   = req_i[sel];
  assign mem_addr_o  = addr_i[sel];
  assign mem_wen_o   = wen_i[sel];
  assign mem_wdata_o = wdata_i[sel];
  assign mem_fire    = mem_req_o & mem_gnt_i;

  // Grant passes through in the same cycle
  always_comb begin
    gnt_o = '0;
    if (mem_fire) begin
      gnt_o[sel] = 1'b1;
    end
  end

  // Steer the response by the registered index
  always_comb begin
    rvalid_o = '0;
    if (mem_rvalid_i) begin
      rvalid_o[rd_id_q] = 1'b1;
    end
  end
  assign rdata_o = mem_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q     <= '0;
      lock_q    <= 1'b0;
      lock_id_q <= '0;
      rd_id_q   <= '0;
    end else begin
      lock_q    <= mem_req_o & ~mem_gnt_i;
      lock_id_q <= sel;
      // Move past the winner
      if (mem_fire) begin
        ptr_q <= sel + port_id_t'(1);
      end
      if (mem_fire && mem_wen_o) begin
        rd_id_q <= sel;
      end
    end
  end

  // Stalled memory request keeps its owner and payload until granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mem_req_o && !mem_gnt_i) |=> mem_req_o && $stable(mem_addr_o)
      && $stable(mem_wen_o) && $stable(mem_wdata_o));

  // Memory answers only reads granted one cycle before
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rvalid_i |-> $past(mem_fire && mem_wen_o));

endmodule

/* logic/stream_sink.sv */
/*
 * Store channel. Takes len Z words and writes them at base, base+stride, ...
 * Writes get no response, so done follows the grant of the last write.
 */
`include "streamer_cfg.svh"

module stream_sink
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  start_i,
  input  addr_t base_i,
  input  len_t  len_i,
  input  len_t  stride_i,
  input  logic  z_valid_i,
  input  data_t z_data_i,
  output logic  z_ready_o,
  output logic  req_o,
  output addr_t addr_o,
  output data_t wdata_o,
  input  logic  req_gnt_i,
  output logic  done_o
);

  localparam int unsigned DEPTH = `STREAMER_STORE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  addr_t            addr_q;
  len_t             len_q;
  len_t             stride_q;
  len_t             taken_q;
  len_t             written_q;
  logic             done_q;
  // Address and data queue, same slot index
  addr_t            fifo_addr [DEPTH];
  data_t            fifo_data [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic             push;
  logic             pop;

  // Stop taking words when full or when the job count is reached
  assign z_ready_o = (fifo_cnt_q != CNT_W'(DEPTH)) && (taken_q != len_q);
  assign push      = z_valid_i & z_ready_o;

  // FIFO head drives the write request
  assign req_o   = (fifo_cnt_q != '0);
  assign addr_o  = fifo_addr[rd_ptr_q];
  assign wdata_o = fifo_data[rd_ptr_q];
  assign pop     = req_o & req_gnt_i;
  assign done_o  = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q     <= '0;
      len_q      <= '0;
      stride_q   <= '0;
      taken_q    <= '0;
      written_q  <= '0;
      done_q     <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (start_i) begin
        addr_q    <= base_i;
        len_q     <= len_i;
        stride_q  <= stride_i;
        taken_q   <= '0;
        written_q <= '0;
        done_q    <= 1'b0;
      end else begin
        // Tag each accepted word with the next strided address
        if (push) begin
          addr_q  <= addr_q + addr_t'(stride_q);
          taken_q <= taken_q + len_t'(1);
        end
        if (pop) begin
          written_q <= written_q + len_t'(1);
          if (written_q == len_q - len_t'(1)) begin
            done_q <= 1'b1;
          end
        end
      end
      case ({push, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: ;
      endcase
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_addr[wr_ptr_q] <= addr_q;
      fifo_data[wr_ptr_q] <= z_data_i;
    end
  end

  // Pending write must hold address and data until the mux grants it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_o && !req_gnt_i) |=> req_o && $stable(addr_o) && $stable(wdata_o));

endmodule

/* logic/stream_source.sv */
/*
 * Load channel. Reads len words at base, base+stride, ... and streams them in order.
 * Len must be at least 1. Reads in flight plus FIFO fill never exceed the load depth.
 */
`include "streamer_cfg.svh"

module stream_source
  import streamer_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  start_i,
  input  addr_t base_i,
  input  len_t  len_i,
  input  len_t  stride_i,
  output logic  req_o,
  output addr_t addr_o,
  input  logic  req_gnt_i,
  input  logic  rvalid_i,
  input  data_t rdata_i,
  output logic  stream_valid_o,
  output data_t stream_data_o,
  input  logic  stream_ready_i,
  output logic  done_o
);

  localparam int unsigned DEPTH = `STREAMER_LOAD_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Job config and progress
  addr_t            addr_q;
  len_t             len_q;
  len_t             stride_q;
  len_t             issued_q;
  len_t             sent_q;
  logic             done_q;
  // Granted reads still waiting for rvalid
  logic [CNT_W-1:0] pend_q;
  // Response FIFO
  data_t            fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic             rd_fire;
  logic             pop;
  logic [CNT_W:0]   credit_used;

  // Every read in flight owns one FIFO slot
  assign credit_used = {1'b0, pend_q} + {1'b0, fifo_cnt_q};
  // Held until granted since credits only shrink on a grant
  assign req_o       = (issued_q != len_q) && (credit_used < (CNT_W + 1)'(DEPTH));
  assign addr_o      = addr_q;
  assign rd_fire     = req_o & req_gnt_i;

  assign stream_valid_o = (fifo_cnt_q != '0);
  assign stream_data_o  = fifo_mem[rd_ptr_q];
  assign pop            = stream_valid_o & stream_ready_i;
  assign done_o         = done_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q   <= '0;
      len_q    <= '0;
      stride_q <= '0;
      issued_q <= '0;
      sent_q   <= '0;
      done_q   <= 1'b0;
    end else if (start_i) begin
      addr_q   <= base_i;
      len_q    <= len_i;
      stride_q <= stride_i;
      issued_q <= '0;
      sent_q   <= '0;
      done_q   <= 1'b0;
    end else begin
      // Next strided address after each granted read
      if (rd_fire) begin
        addr_q   <= addr_q + addr_t'(stride_q);
        issued_q <= issued_q + len_t'(1);
      end
      // Done once the last word has left on the stream
      if (pop) begin
        sent_q <= sent_q + len_t'(1);
        if (sent_q == len_q - len_t'(1)) begin
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      case ({rd_fire, rvalid_i})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: ;
      endcase
      case ({rvalid_i, pop})
        2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
        2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
        default: ;
      endcase
      if (rvalid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // FIFO storage, no reset needed on payload
  always_ff @(posedge clk_i) begin
    if (rvalid_i) begin
      fifo_mem[wr_ptr_q] <= rdata_i;
    end
  end

  // Mux only answers our own reads, and the credit check leaves room
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i |-> (pend_q != '0) && (fifo_cnt_q != CNT_W'(DEPTH)));

endmodule

/* logic/streamer_ctrl.sv */
/*
 * Job controller. One start pulse launches all channels with the same len and stride.
 * A start during RUN or FINISH is dropped.
 */
`include "streamer_cfg.svh"

module streamer_ctrl
  import streamer_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         start_i,
  input  logic [`STREAMER_NUM_SRC-1:0] src_done_i,
  input  logic                         sink_done_i,
  output logic                         chan_start_o,
  output logic                         busy_o,
  output logic                         done_o
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        all_done;

  // Channel done levels are cleared by the next chan_start
  assign all_done = (&src_done_i) & sink_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        // Wait for every stream drained and the last store granted
        if (all_done) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Start only accepted while idle
  assign chan_start_o = (state_q == IDLE) & start_i;
  // Busy drops in the done cycle
  assign busy_o       = (state_q == RUN);
  assign done_o       = (state_q == FINISH);

  // Stale done levels from the last job would end RUN at once
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    chan_start_o |=> (src_done_i == '0) && !sink_done_i);

endmodule

/* logic/streamer_pkg.sv */
/*
 * Shared types of the streamer. Widths come from the cfg header.
 */
`include "streamer_cfg.svh"

package streamer_pkg;

  // Word address on the memory port
  typedef logic [`STREAMER_ADDR_W-1:0] addr_t;

  // One memory or stream word
  typedef logic [`STREAMER_DATA_W-1:0] data_t;

  // Word count or stride in words
  typedef logic [`STREAMER_LEN_W-1:0] len_t;

  // Mux requester index
  // 0..2 are the X, W, Y sources, 3 is the Z sink
  typedef logic [1:0] port_id_t;

  // Job controller states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } ctrl_state_t;

endpackage

/* include/streamer_cfg.svh */
/*
 * Streamer build constants. Memory is word addressed and every access is a full word.
 * Both FIFO depths must be powers of two, and the sources plus the sink make four ports.
 */
`ifndef STREAMER_CFG_SVH
`define STREAMER_CFG_SVH

// Word address width
`define STREAMER_ADDR_W 16
// Memory and stream word width
`define STREAMER_DATA_W 32
// Length and stride fields
`define STREAMER_LEN_W 8
// Load channels X, W and Y
`define STREAMER_NUM_SRC 3
// Per-source response FIFO, also the read credit limit
`define STREAMER_LOAD_DEPTH 4
// Store FIFO between Z stream and memory
`define STREAMER_STORE_DEPTH 2

`endif
